// File: src/hdc_pkg.sv
package hdc_pkg;

    // ========================================
    // widths with a meaning
    // ========================================

    // one generator word, also one bus data word
    typedef logic [31:0] word_t;

    // item number, 65536 items max
    typedef logic [15:0] item_idx_t;

    // word address from bus bits 11:2
    typedef logic [9:0] reg_addr_t;

    // AXI-Lite slave FSM
    typedef enum logic [2:0] {
        idle,
        aw_wait,
        w_wait,
        write_resp,
        read_fetch,
        read_resp
    } axil_state_e;

    // xorshift32 start state, reloaded for every run
    localparam word_t XORSHIFT_SEED = 32'h92d68ca2;

    // ========================================
    // register map, word addresses
    // ========================================

    // bit 0 gen (self clearing), bit 1 hv_valid (read only)
    localparam reg_addr_t CTRL_ADDR     = 10'd0;
    // low 16 bits hold the target item
    localparam reg_addr_t ITEM_NUM_ADDR = 10'd1;
    // byte 0x100, hypervector word i at base + i
    localparam reg_addr_t HV_BASE_ADDR  = 10'd64;

endpackage

// File: src/hv_word_if.sv
`timescale 1ns/100ps

// word stream from the generator to the capture buffer
// no back-pressure, every valid word is taken
interface hv_word_if;

    // one-cycle strobe per word
    logic               valid;
    hdc_pkg::word_t     word;
    // item the word belongs to
    hdc_pkg::item_idx_t item;
    // final word of an item
    logic               last;

    modport producer (output valid, output word, output item, output last);

    modport buffer (input valid, input word, input item, input last);

endinterface

// File: src/item_memory_gen.sv
`timescale 1ns/100ps

module item_memory_gen #(
    parameter int HV_WORDS = 4
) (
    input  logic        AXIS_ACLK,
    input  logic        S_AXI_ARESETN,
    input  logic        gen,
    hv_word_if.producer hv_port
);

    // word counter needs at least one bit, even for HV_WORDS 1
    localparam int               CNT_W     = (HV_WORDS > 1) ? $clog2(HV_WORDS) : 1;
    localparam logic [CNT_W-1:0] LAST_WORD = CNT_W'(HV_WORDS - 1);

    hdc_pkg::word_t     rng_q;
    hdc_pkg::word_t     rng_next;
    logic [CNT_W-1:0]   word_cnt;
    hdc_pkg::item_idx_t item_cnt;
    logic               word_wrap;

    // one xorshift32 step: left 13, right 17, left 5
    function automatic hdc_pkg::word_t xorshift32(input hdc_pkg::word_t x);
        hdc_pkg::word_t y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    assign rng_next  = xorshift32(rng_q);
    assign word_wrap = (word_cnt == LAST_WORD);

    // ========================================
    // state and counters
    // ========================================

    // held at seed and zero while gen is low
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN || !gen) begin
            rng_q    <= hdc_pkg::XORSHIFT_SEED;
            word_cnt <= '0;
            item_cnt <= '0;
        end else begin
            rng_q <= rng_next;
            // item advances when its last word goes out
            if (word_wrap) begin
                word_cnt <= '0;
                item_cnt <= item_cnt + 16'd1;
            end else begin
                word_cnt <= word_cnt + CNT_W'(1);
            end
        end
    end

    // ========================================
    // stream outputs
    // ========================================

    // one word per cycle while gen is high
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN || !gen) begin
            hv_port.valid <= 1'b0;
        end else begin
            hv_port.valid <= 1'b1;
        end
    end

    // payload, qualified by valid
    always_ff @(posedge AXIS_ACLK) begin
        hv_port.word <= rng_next;
        hv_port.item <= item_cnt;
        hv_port.last <= word_wrap;
    end

endmodule

// File: src/hv_capture_buffer.sv
`timescale 1ns/100ps

module hv_capture_buffer #(
    parameter int HV_WORDS = 4
) (
    input  logic                          AXIS_ACLK,
    input  logic                          S_AXI_ARESETN,
    hv_word_if.buffer                     hv_port,
    input  hdc_pkg::item_idx_t            target_item,
    output logic                          capture_done,
    output logic                          hv_valid,
    output hdc_pkg::word_t [HV_WORDS-1:0] hv_data
);

    // assembly register, first word of an item ends at index 0
    hdc_pkg::word_t [HV_WORDS-1:0] asm_q;
    hdc_pkg::word_t [HV_WORDS-1:0] asm_next;
    // target's last word on the bus
    logic                          hit;

    // shift down, new word enters at the top
    always_comb begin
        for (int i = 0; i < HV_WORDS - 1; i++) begin
            asm_next[i] = asm_q[i + 1];
        end
        asm_next[HV_WORDS-1] = hv_port.word;
    end

    assign hit = hv_port.valid && hv_port.last && (hv_port.item == target_item);

    always_ff @(posedge AXIS_ACLK) begin
        if (hv_port.valid) begin
            asm_q <= asm_next;
        end
    end

    // ========================================
    // held hypervector
    // ========================================

    // survives later runs, only reset clears it
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            hv_data      <= '0;
            hv_valid     <= 1'b0;
            capture_done <= 1'b0;
        end else begin
            // pulse for one cycle after the last word
            capture_done <= hit;
            if (hit) begin
                hv_data  <= asm_next;
                hv_valid <= 1'b1;
            end
        end
    end

endmodule

// File: src/axil_reg_slave.sv
`timescale 1ns/100ps

module axil_reg_slave #(
    parameter int HV_WORDS = 4
) (
    input  logic                          AXIS_ACLK,
    input  logic                          S_AXI_ARESETN,
    // write address
    input  logic [31:0]                   awaddr,
    input  logic                          awvalid,
    output logic                          awready,
    // write data
    input  hdc_pkg::word_t                wdata,
    input  logic                          wvalid,
    output logic                          wready,
    // write response
    output logic                          bvalid,
    input  logic                          bready,
    // read address
    input  logic [31:0]                   araddr,
    input  logic                          arvalid,
    output logic                          arready,
    // read data
    output hdc_pkg::word_t                rdata,
    output logic                          rvalid,
    input  logic                          rready,
    // towards generator and buffer
    output logic                          gen,
    output hdc_pkg::item_idx_t            target_item,
    input  logic                          capture_done,
    input  logic                          hv_valid,
    input  hdc_pkg::word_t [HV_WORDS-1:0] hv_data
);

    hdc_pkg::axil_state_e state;
    hdc_pkg::reg_addr_t   write_addr;
    hdc_pkg::reg_addr_t   read_addr;
    hdc_pkg::word_t       write_data;
    // both halves of a write in hand
    logic                 enter_wr;
    // first cycle of write_resp, register update
    logic                 wr_commit;

    // ========================================
    // handshake outputs
    // ========================================

    assign awready = (state == hdc_pkg::idle) || (state == hdc_pkg::w_wait);
    assign wready  = (state == hdc_pkg::idle) || (state == hdc_pkg::aw_wait);
    // writes win in idle, so AR is only ready without one
    assign arready = (state == hdc_pkg::idle) && !awvalid && !wvalid;
    assign bvalid  = (state == hdc_pkg::write_resp);
    assign rvalid  = (state == hdc_pkg::read_resp);

    assign enter_wr = ((state == hdc_pkg::idle) && awvalid && wvalid)
                   || ((state == hdc_pkg::aw_wait) && wvalid)
                   || ((state == hdc_pkg::w_wait) && awvalid);

    // ========================================
    // slave FSM
    // ========================================

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            state     <= hdc_pkg::idle;
            wr_commit <= 1'b0;
        end else begin
            wr_commit <= enter_wr;
            case (state)
                hdc_pkg::idle: begin
                    if (awvalid && wvalid) begin
                        state <= hdc_pkg::write_resp;
                    end else if (awvalid) begin
                        state <= hdc_pkg::aw_wait;
                    end else if (wvalid) begin
                        state <= hdc_pkg::w_wait;
                    end else if (arvalid) begin
                        state <= hdc_pkg::read_fetch;
                    end
                end
                // address first, wait for data
                hdc_pkg::aw_wait: begin
                    if (wvalid) begin
                        state <= hdc_pkg::write_resp;
                    end
                end
                // data first, wait for address
                hdc_pkg::w_wait: begin
                    if (awvalid) begin
                        state <= hdc_pkg::write_resp;
                    end
                end
                hdc_pkg::write_resp: begin
                    if (bready) begin
                        state <= hdc_pkg::idle;
                    end
                end
                hdc_pkg::read_fetch: begin
                    state <= hdc_pkg::read_resp;
                end
                hdc_pkg::read_resp: begin
                    if (rready) begin
                        state <= hdc_pkg::idle;
                    end
                end
                default: begin
                    state <= hdc_pkg::idle;
                end
            endcase
        end
    end

    // address and data latched on their handshakes
    always_ff @(posedge AXIS_ACLK) begin
        if (awready && awvalid) begin
            write_addr <= awaddr[11:2];
        end
        if (wready && wvalid) begin
            write_data <= wdata;
        end
        if (arready && arvalid) begin
            read_addr <= araddr[11:2];
        end
    end

    // ========================================
    // register write
    // ========================================

    // a new start wins over a capture in the same cycle
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            gen         <= 1'b0;
            target_item <= '0;
        end else begin
            if (wr_commit && (write_addr == hdc_pkg::CTRL_ADDR) && write_data[0]) begin
                gen <= 1'b1;
            end else if (capture_done) begin
                gen <= 1'b0;
            end
            if (wr_commit && (write_addr == hdc_pkg::ITEM_NUM_ADDR)) begin
                target_item <= write_data[15:0];
            end
        end
    end

    // ========================================
    // register read
    // ========================================

    // fetched one cycle before RVALID, unmapped reads give zero
    always_ff @(posedge AXIS_ACLK) begin
        if (state == hdc_pkg::read_fetch) begin
            rdata <= '0;
            case (read_addr)
                hdc_pkg::CTRL_ADDR: begin
                    rdata <= {30'd0, hv_valid, gen};
                end
                hdc_pkg::ITEM_NUM_ADDR: begin
                    rdata <= {16'd0, target_item};
                end
                default: begin
                    // hypervector window
                    for (int i = 0; i < HV_WORDS; i++) begin
                        if (read_addr == hdc_pkg::HV_BASE_ADDR + hdc_pkg::reg_addr_t'(i)) begin
                            rdata <= hv_data[i];
                        end
                    end
                end
            endcase
        end
    end

endmodule

// File: src/hdc_item_memory_top.sv
`timescale 1ns/100ps

module hdc_item_memory_top #(
    parameter int HV_WORDS = 4
) (
    input  logic        AXIS_ACLK,
    input  logic        S_AXI_ARESETN,
    // AXI-Lite slave
    input  logic [31:0] S_AXI_AWADDR,
    input  logic        S_AXI_AWVALID,
    output logic        S_AXI_AWREADY,
    input  logic [31:0] S_AXI_WDATA,
    input  logic        S_AXI_WVALID,
    output logic        S_AXI_WREADY,
    output logic [1:0]  S_AXI_BRESP,
    output logic        S_AXI_BVALID,
    input  logic        S_AXI_BREADY,
    input  logic [31:0] S_AXI_ARADDR,
    input  logic        S_AXI_ARVALID,
    output logic        S_AXI_ARREADY,
    output logic [31:0] S_AXI_RDATA,
    output logic [1:0]  S_AXI_RRESP,
    output logic        S_AXI_RVALID,
    input  logic        S_AXI_RREADY
);

    // ========================================
    // internal wiring
    // ========================================

    hv_word_if hv_bus ();

    logic                          gen;
    hdc_pkg::item_idx_t            target_item;
    logic                          capture_done;
    logic                          hv_valid;
    hdc_pkg::word_t [HV_WORDS-1:0] hv_data;

    // always OKAY
    assign S_AXI_BRESP = 2'b00;
    assign S_AXI_RRESP = 2'b00;

    // producer, xorshift32 words
    item_memory_gen #(
        .HV_WORDS (HV_WORDS)
    ) item_memory_gen_i (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .gen           (gen),
        .hv_port       (hv_bus.producer)
    );

    // buffer, holds the target hypervector
    hv_capture_buffer #(
        .HV_WORDS (HV_WORDS)
    ) hv_capture_buffer_i (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .hv_port       (hv_bus.buffer),
        .target_item   (target_item),
        .capture_done  (capture_done),
        .hv_valid      (hv_valid),
        .hv_data       (hv_data)
    );

    // consumer, register file on the bus
    axil_reg_slave #(
        .HV_WORDS (HV_WORDS)
    ) axil_reg_slave_i (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .awaddr        (S_AXI_AWADDR),
        .awvalid       (S_AXI_AWVALID),
        .awready       (S_AXI_AWREADY),
        .wdata         (S_AXI_WDATA),
        .wvalid        (S_AXI_WVALID),
        .wready        (S_AXI_WREADY),
        .bvalid        (S_AXI_BVALID),
        .bready        (S_AXI_BREADY),
        .araddr        (S_AXI_ARADDR),
        .arvalid       (S_AXI_ARVALID),
        .arready       (S_AXI_ARREADY),
        .rdata         (S_AXI_RDATA),
        .rvalid        (S_AXI_RVALID),
        .rready        (S_AXI_RREADY),
        .gen           (gen),
        .target_item   (target_item),
        .capture_done  (capture_done),
        .hv_valid      (hv_valid),
        .hv_data       (hv_data)
    );

endmodule

// File: tests/tb_clock_gen.sv
`timescale 1ns/100ps

// 10 ns clock, reset held low for the first cycles
module tb_clock_gen #(
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // release on a rising edge, reset is synchronous
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

// File: tests/tb_hdc_item_memory.sv
`timescale 1ns/100ps

module tb_hdc_item_memory;

    localparam int HV_WORDS   = 4;
    localparam int MAX_ITEM   = 50;
    localparam int RAND_RUNS  = 5;
    localparam int BP_RUNS    = 2;
    localparam int NUM_RUNS   = 1 + RAND_RUNS + BP_RUNS;
    // worst bus access with the longest stall
    localparam int BUS_CYCLES = 30;
    localparam int BUS_OPS    = 20 + NUM_RUNS * (HV_WORDS + 4);
    localparam int WATCHDOG_CYCLES = NUM_RUNS * (MAX_ITEM + 2) * HV_WORDS + BUS_OPS * BUS_CYCLES;
    localparam int POLL_LIMIT = (MAX_ITEM + 2) * HV_WORDS;

    // round trip value per write order
    localparam hdc_pkg::word_t RT_DATA [3] = '{32'habcd1234, 32'h12340033, 32'hffff0007};

    logic           aclk;
    logic           aresetn;
    logic [31:0]    awaddr;
    logic           awvalid;
    logic           S_AXI_AWREADY;
    hdc_pkg::word_t wdata;
    logic           wvalid;
    logic           S_AXI_WREADY;
    logic [1:0]     S_AXI_BRESP;
    logic           S_AXI_BVALID;
    logic           bready;
    logic [31:0]    araddr;
    logic           arvalid;
    logic           S_AXI_ARREADY;
    hdc_pkg::word_t S_AXI_RDATA;
    logic [1:0]     S_AXI_RRESP;
    logic           S_AXI_RVALID;
    logic           rready;
    hdc_pkg::word_t data;
    int             pass_count = 0;
    int             fail_count = 0;

    tb_clock_gen clock_gen_i (
        .clk   (aclk),
        .rst_n (aresetn)
    );

    hdc_item_memory_top #(
        .HV_WORDS (HV_WORDS)
    ) hdc_item_memory_top_i (
        .AXIS_ACLK     (aclk),
        .S_AXI_ARESETN (aresetn),
        .S_AXI_AWADDR  (awaddr),
        .S_AXI_AWVALID (awvalid),
        .S_AXI_AWREADY (S_AXI_AWREADY),
        .S_AXI_WDATA   (wdata),
        .S_AXI_WVALID  (wvalid),
        .S_AXI_WREADY  (S_AXI_WREADY),
        .S_AXI_BRESP   (S_AXI_BRESP),
        .S_AXI_BVALID  (S_AXI_BVALID),
        .S_AXI_BREADY  (bready),
        .S_AXI_ARADDR  (araddr),
        .S_AXI_ARVALID (arvalid),
        .S_AXI_ARREADY (S_AXI_ARREADY),
        .S_AXI_RDATA   (S_AXI_RDATA),
        .S_AXI_RRESP   (S_AXI_RRESP),
        .S_AXI_RVALID  (S_AXI_RVALID),
        .S_AXI_RREADY  (rready)
    );

    // ========================================
    // reference model and checks
    // ========================================

    // word idx of item k is xorshift step k*HV_WORDS+idx+1 from the seed
    function automatic hdc_pkg::word_t ref_word(input hdc_pkg::item_idx_t item, input int idx);
        hdc_pkg::word_t x;
        int             steps;
        x = 32'h92d68ca2;
        steps = int'(item) * HV_WORDS + idx + 1;
        for (int s = 0; s < steps; s++) begin
            x = x ^ (x << 13);
            x = x ^ (x >> 17);
            x = x ^ (x << 5);
        end
        return x;
    endfunction

    function automatic logic [31:0] byte_addr(input hdc_pkg::reg_addr_t word_addr);
        return {20'd0, word_addr, 2'b00};
    endfunction

    // negative means a random stretch per access
    function automatic int stall_len(input int stall);
        return (stall < 0) ? int'($urandom_range(8, 1)) : stall;
    endfunction

    task automatic check_word(input string name, input hdc_pkg::word_t exp,
                              input hdc_pkg::word_t act);
        if (act === exp) begin
            pass_count++;
            $display("ok       %s = %08h", name, act);
        end else begin
            fail_count++;
            $display("** Error: %s expected %08h actual %08h", name, exp, act);
        end
    endtask

    task automatic check_item(input string name, input hdc_pkg::item_idx_t exp,
                              input hdc_pkg::item_idx_t act);
        if (act === exp) begin
            pass_count++;
            $display("ok       %s = %04h", name, act);
        end else begin
            fail_count++;
            $display("** Error: %s expected %04h actual %04h", name, exp, act);
        end
    endtask

    // response code of the write or read channel
    task automatic check_resp(input string name, input logic [1:0] exp,
                              input logic [1:0] act);
        if (act === exp) begin
            pass_count++;
            $display("ok       %s = %02b", name, act);
        end else begin
            fail_count++;
            $display("** Error: %s expected %02b actual %02b", name, exp, act);
        end
    endtask

    task automatic report_failure(input string msg);
        fail_count++;
        $display("failure: %s", msg);
    endtask

    // ========================================
    // AXI-Lite bus tasks
    // ========================================

    // inputs change on rising edges and outputs are sampled on falling edges
    task automatic send_aw(input hdc_pkg::reg_addr_t word_addr);
        @(posedge aclk);
        awaddr  <= byte_addr(word_addr);
        awvalid <= 1'b1;
        do @(negedge aclk); while (!S_AXI_AWREADY);
        @(posedge aclk);
        awvalid <= 1'b0;
    endtask

    task automatic send_w(input hdc_pkg::word_t value);
        @(posedge aclk);
        wdata  <= value;
        wvalid <= 1'b1;
        do @(negedge aclk); while (!S_AXI_WREADY);
        @(posedge aclk);
        wvalid <= 1'b0;
    endtask

    // BVALID must stay up while BREADY is held low
    task automatic take_bresp(input int stall);
        int n;
        n = stall_len(stall);
        do @(negedge aclk); while (!S_AXI_BVALID);
        check_resp("write response", 2'b00, S_AXI_BRESP);
        repeat (n) begin
            @(negedge aclk);
            if (!S_AXI_BVALID) begin
                report_failure("BVALID dropped before BREADY was raised");
            end
        end
        @(posedge aclk);
        bready <= 1'b1;
        @(negedge aclk);
        @(posedge aclk);
        bready <= 1'b0;
    endtask

    // order 0 sends address and data together, 1 address first and 2 data first
    task automatic bus_write(input hdc_pkg::reg_addr_t word_addr, input hdc_pkg::word_t value,
                             input int order, input int stall);
        if (order == 1) begin
            send_aw(word_addr);
            send_w(value);
        end else if (order == 2) begin
            send_w(value);
            send_aw(word_addr);
        end else begin
            @(posedge aclk);
            awaddr  <= byte_addr(word_addr);
            awvalid <= 1'b1;
            wdata   <= value;
            wvalid  <= 1'b1;
            do @(negedge aclk); while (!(S_AXI_AWREADY && S_AXI_WREADY));
            @(posedge aclk);
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
        end
        take_bresp(stall);
    endtask

    // RDATA must hold while RREADY is low
    task automatic bus_read(input hdc_pkg::reg_addr_t word_addr, input int stall,
                            output hdc_pkg::word_t value);
        int n;
        n = stall_len(stall);
        @(posedge aclk);
        araddr  <= byte_addr(word_addr);
        arvalid <= 1'b1;
        do @(negedge aclk); while (!S_AXI_ARREADY);
        @(posedge aclk);
        arvalid <= 1'b0;
        do @(negedge aclk); while (!S_AXI_RVALID);
        value = S_AXI_RDATA;
        check_resp("read response", 2'b00, S_AXI_RRESP);
        repeat (n) begin
            @(negedge aclk);
            if (!S_AXI_RVALID || S_AXI_RDATA !== value) begin
                report_failure("read response changed before RREADY was raised");
            end
        end
        @(posedge aclk);
        rready <= 1'b1;
        @(negedge aclk);
        @(posedge aclk);
        rready <= 1'b0;
    endtask

    // ========================================
    // one generation run
    // ========================================

    task automatic run_item(input hdc_pkg::item_idx_t item, input int stall, input string tag);
        hdc_pkg::word_t value;
        int             polls;
        bus_write(hdc_pkg::ITEM_NUM_ADDR, {16'd0, item}, int'($urandom_range(2, 0)), stall);
        bus_write(hdc_pkg::CTRL_ADDR, 32'h1, 0, stall);
        polls = 0;
        // wait for gen to clear itself
        do begin
            bus_read(hdc_pkg::CTRL_ADDR, stall, value);
            polls++;
        end while (value[0] && polls < POLL_LIMIT);
        if (value[0]) begin
            report_failure($sformatf("%s: gen never cleared after %0d polls", tag, polls));
            return;
        end
        check_word({tag, " ctrl"}, 32'h2, value);
        bus_read(hdc_pkg::ITEM_NUM_ADDR, stall, value);
        check_item({tag, " item_num"}, item, value[15:0]);
        for (int i = 0; i < HV_WORDS; i++) begin
            bus_read(hdc_pkg::HV_BASE_ADDR + hdc_pkg::reg_addr_t'(i), stall, value);
            check_word($sformatf("%s word %0d", tag, i), ref_word(item, i), value);
        end
    endtask

    // ========================================
    // stimulus
    // ========================================

    initial begin
        void'($urandom(32'h7bda));
        awaddr  <= '0;
        awvalid <= 1'b0;
        wdata   <= '0;
        wvalid  <= 1'b0;
        bready  <= 1'b0;
        araddr  <= '0;
        arvalid <= 1'b0;
        rready  <= 1'b0;
        @(posedge aresetn);
        @(negedge aclk);
        if (S_AXI_BVALID || S_AXI_RVALID) begin
            report_failure("a response is pending right after reset");
        end
        // reset state
        bus_read(hdc_pkg::CTRL_ADDR, 0, data);
        check_word("reset ctrl", 32'h0, data);
        bus_read(hdc_pkg::ITEM_NUM_ADDR, 0, data);
        check_word("reset item_num", 32'h0, data);
        for (int i = 0; i < HV_WORDS; i++) begin
            bus_read(hdc_pkg::HV_BASE_ADDR + hdc_pkg::reg_addr_t'(i), 0, data);
            check_word($sformatf("reset word %0d", i), 32'h0, data);
        end
        // item register in all three write orders
        for (int o = 0; o < 3; o++) begin
            bus_write(hdc_pkg::ITEM_NUM_ADDR, RT_DATA[o], o, 0);
            bus_read(hdc_pkg::ITEM_NUM_ADDR, 0, data);
            check_word($sformatf("item_num round trip order %0d", o),
                       {16'd0, RT_DATA[o][15:0]}, data);
        end
        run_item(16'd0, 0, "item 0");
        for (int r = 0; r < RAND_RUNS; r++) begin
            run_item(hdc_pkg::item_idx_t'($urandom_range(MAX_ITEM, 0)), 0,
                     $sformatf("random run %0d", r));
        end
        // BREADY and RREADY low for random stretches
        for (int r = 0; r < BP_RUNS; r++) begin
            run_item(hdc_pkg::item_idx_t'($urandom_range(MAX_ITEM, 0)), -1,
                     $sformatf("back-pressure run %0d", r));
        end
        $display("checks: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // stops a hung run
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge aclk);
        $display("timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Result: FAILED");
        $finish;
    end

endmodule

// File: sim.f
src/hdc_pkg.sv
src/hv_word_if.sv
src/item_memory_gen.sv
src/hv_capture_buffer.sv
src/axil_reg_slave.sv
src/hdc_item_memory_top.sv
tests/tb_clock_gen.sv
tests/tb_hdc_item_memory.sv

// File: run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator, pass only if the log says so
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f sim.f --top-module tb_hdc_item_memory -o tb_sim
./obj_dir/tb_sim | tee sim.log

if grep -qx "Result: PASSED" sim.log; then
    exit 0
else
    echo "simulation did not pass, see sim.log"
    exit 1
fi
